//--- src/rob_cfg.svh
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// buffer geometry
`define ROB_DEPTH 16
`define ROB_TAG_W 4

// payload widths
`define ROB_DATA_W 32
`define ROB_ADDR_W 32
`define ROB_REG_W 5

`endif

//--- src/rob_pkg.sv
`include "rob_cfg.svh"

package rob_pkg;

    // entry tag, indexes the circular buffer
    typedef logic [`ROB_TAG_W-1:0] tag_t;

    // architectural destination register
    typedef logic [`ROB_REG_W-1:0] regnm_t;

    typedef logic [`ROB_DATA_W-1:0] data_t;

    // jump target and redirect pc
    typedef logic [`ROB_ADDR_W-1:0] addr_t;

    // commit side of the control FSM
    typedef enum logic {
        st_run,
        st_flush
    } commit_state_t;

endpackage

//--- src/rob_if.sv
`timescale 1ns/1ps

interface rob_alloc_if;
    import rob_pkg::*;

    logic   we;
    tag_t   tag;
    regnm_t regnm;
    logic   is_store;
    logic   pred_taken;

    modport ctrl (
        output we,
        output tag
    );

    modport entry (
        input we,
        input tag,
        input regnm,
        input is_store,
        input pred_taken
    );
endinterface

interface rob_head_if;
    import rob_pkg::*;

    logic   valid;
    logic   ready;
    logic   is_store;
    logic   mispredict;
    regnm_t regnm;
    data_t  data;
    addr_t  target;
    tag_t   tag;

    modport entry (
        output valid,
        output ready,
        output is_store,
        output mispredict,
        output regnm,
        output data,
        output target,
        output tag
    );

    modport ctrl (
        input valid,
        input ready,
        input mispredict
    );

    modport retire (
        input is_store,
        input mispredict,
        input regnm,
        input data,
        input target,
        input tag
    );
endinterface

//--- src/rob_ctrl.sv
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_ctrl (
    input  logic          clk,
    input  logic          rst,
    input  logic          alloc_en,
    rob_alloc_if.ctrl     alloc,
    rob_head_if.ctrl      head,
    output rob_pkg::tag_t head_ptr,
    output logic          commit_fire,
    output logic          flush_clear,
    output logic          full
);
    import rob_pkg::*;

    tag_t                tail_ptr;
    logic [`ROB_TAG_W:0] count;
    commit_state_t       state;
    logic                mispredict_commit;

    // head may leave only once its result is in
    assign commit_fire = (state == st_run) && head.valid && head.ready;
    assign mispredict_commit = commit_fire && head.mispredict;

    assign flush_clear = (state == st_flush);
    assign full = (count == `ROB_DEPTH) || (state == st_flush);

    // front end gets the tag in the same cycle
    assign alloc.tag = tail_ptr;
    // younger allocations die with the mispredicted branch
    assign alloc.we = alloc_en && !full && !mispredict_commit;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
            state    <= st_run;
        end else begin
            case (state)
                st_run: begin
                    if (alloc.we) begin
                        tail_ptr <= tail_ptr + 1'b1;
                    end
                    if (commit_fire) begin
                        head_ptr <= head_ptr + 1'b1;
                    end
                    case ({alloc.we, commit_fire})
                        2'b10: count <= count + 1'b1;
                        2'b01: count <= count - 1'b1;
                        default: count <= count;
                    endcase
                    if (mispredict_commit) begin
                        state <= st_flush;
                    end
                end
                st_flush: begin
                    // buffer restarts empty at tag 0
                    head_ptr <= '0;
                    tail_ptr <= '0;
                    count    <= '0;
                    state    <= st_run;
                end
                default: begin
                    state <= st_run;
                end
            endcase
        end
    end

endmodule

//--- src/rob_entry_file.sv
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_entry_file (
    input  logic           clk,
    input  logic           rst,
    rob_alloc_if.entry     alloc,
    rob_head_if.entry      head,
    input  rob_pkg::tag_t  head_ptr,
    input  logic           commit_fire,
    input  logic           flush_clear,
    input  logic           ex_en,
    input  rob_pkg::tag_t  ex_tag,
    input  rob_pkg::data_t ex_data,
    input  logic           ex_taken,
    input  rob_pkg::addr_t ex_target,
    input  logic           lsb_en,
    input  rob_pkg::tag_t  lsb_tag,
    input  rob_pkg::data_t lsb_data
);
    import rob_pkg::*;

    logic [`ROB_DEPTH-1:0] valid_q;
    logic [`ROB_DEPTH-1:0] ready_q;
    logic [`ROB_DEPTH-1:0] store_q;
    logic [`ROB_DEPTH-1:0] pred_q;
    logic [`ROB_DEPTH-1:0] actual_q;
    regnm_t                regnm_q [`ROB_DEPTH];
    data_t                 data_q [`ROB_DEPTH];
    addr_t                 target_q [`ROB_DEPTH];

    logic ex_hit;
    logic lsb_hit;

    // stale completions are dropped
    assign ex_hit = ex_en && valid_q[ex_tag];
    assign lsb_hit = lsb_en && valid_q[lsb_tag];

    always_ff @(posedge clk) begin
        if (rst || flush_clear) begin
            valid_q <= '0;
            ready_q <= '0;
        end else begin
            if (commit_fire) begin
                valid_q[head_ptr] <= 1'b0;
            end
            if (alloc.we) begin
                valid_q[alloc.tag] <= 1'b1;
                ready_q[alloc.tag] <= 1'b0;
            end
            if (ex_hit) begin
                ready_q[ex_tag] <= 1'b1;
            end
            if (lsb_hit) begin
                ready_q[lsb_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc.we) begin
            regnm_q[alloc.tag] <= alloc.regnm;
            store_q[alloc.tag] <= alloc.is_store;
            pred_q[alloc.tag] <= alloc.pred_taken;
            // non-branches never see a mismatch
            actual_q[alloc.tag] <= alloc.pred_taken;
        end
        if (ex_hit) begin
            data_q[ex_tag] <= ex_data;
            actual_q[ex_tag] <= ex_taken;
            target_q[ex_tag] <= ex_target;
        end
        if (lsb_hit) begin
            data_q[lsb_tag] <= lsb_data;
        end
    end

    // oldest entry
    assign head.valid = valid_q[head_ptr];
    assign head.ready = ready_q[head_ptr];
    assign head.is_store = store_q[head_ptr];
    assign head.mispredict = pred_q[head_ptr] != actual_q[head_ptr];
    assign head.regnm = regnm_q[head_ptr];
    assign head.data = data_q[head_ptr];
    assign head.target = target_q[head_ptr];
    assign head.tag = head_ptr;

endmodule

//--- src/rob_retire.sv
`timescale 1ns/1ps

module rob_retire (
    input  logic            clk,
    input  logic            rst,
    input  logic            commit_fire,
    rob_head_if.retire      head,
    output logic            rf_we,
    output rob_pkg::regnm_t rf_regnm,
    output rob_pkg::data_t  rf_data,
    output rob_pkg::tag_t   rf_tag,
    output logic            store_release,
    output rob_pkg::tag_t   store_tag,
    output logic            flush,
    output rob_pkg::addr_t  redirect_pc
);
    import rob_pkg::*;

    logic commit_reg;
    logic commit_store;

    assign commit_reg = commit_fire && !head.is_store;
    assign commit_store = commit_fire && head.is_store;

    // strobes last one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rf_we         <= 1'b0;
            store_release <= 1'b0;
            flush         <= 1'b0;
        end else begin
            rf_we         <= commit_reg;
            store_release <= commit_store;
            // a mispredicted branch still writes its register
            flush         <= commit_fire && head.mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (commit_fire) begin
            rf_regnm    <= head.regnm;
            rf_data     <= head.data;
            rf_tag      <= head.tag;
            store_tag   <= head.tag;
            redirect_pc <= head.target;
        end
    end

endmodule

//--- src/rob_top.sv
`timescale 1ns/1ps

module rob_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            alloc_en,
    input  rob_pkg::regnm_t alloc_regnm,
    input  logic            alloc_is_store,
    input  logic            alloc_pred_taken,
    output rob_pkg::tag_t   alloc_tag,
    output logic            full,
    input  logic            ex_en,
    input  rob_pkg::tag_t   ex_tag,
    input  rob_pkg::data_t  ex_data,
    input  logic            ex_taken,
    input  rob_pkg::addr_t  ex_target,
    input  logic            lsb_en,
    input  rob_pkg::tag_t   lsb_tag,
    input  rob_pkg::data_t  lsb_data,
    output logic            rf_we,
    output rob_pkg::regnm_t rf_regnm,
    output rob_pkg::data_t  rf_data,
    output rob_pkg::tag_t   rf_tag,
    output logic            store_release,
    output rob_pkg::tag_t   store_tag,
    output logic            flush,
    output rob_pkg::addr_t  redirect_pc
);
    import rob_pkg::*;

    tag_t head_ptr;
    logic commit_fire;
    logic flush_clear;

    rob_alloc_if alloc_if ();
    rob_head_if  head_if ();

    // allocation fields from the front end
    assign alloc_if.regnm = alloc_regnm;
    assign alloc_if.is_store = alloc_is_store;
    assign alloc_if.pred_taken = alloc_pred_taken;
    assign alloc_tag = alloc_if.tag;

    rob_ctrl rob_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .alloc_en    (alloc_en),
        .alloc       (alloc_if.ctrl),
        .head        (head_if.ctrl),
        .head_ptr    (head_ptr),
        .commit_fire (commit_fire),
        .flush_clear (flush_clear),
        .full        (full)
    );

    rob_entry_file rob_entry_file_i (
        .clk         (clk),
        .rst         (rst),
        .alloc       (alloc_if.entry),
        .head        (head_if.entry),
        .head_ptr    (head_ptr),
        .commit_fire (commit_fire),
        .flush_clear (flush_clear),
        .ex_en       (ex_en),
        .ex_tag      (ex_tag),
        .ex_data     (ex_data),
        .ex_taken    (ex_taken),
        .ex_target   (ex_target),
        .lsb_en      (lsb_en),
        .lsb_tag     (lsb_tag),
        .lsb_data    (lsb_data)
    );

    rob_retire rob_retire_i (
        .clk           (clk),
        .rst           (rst),
        .commit_fire   (commit_fire),
        .head          (head_if.retire),
        .rf_we         (rf_we),
        .rf_regnm      (rf_regnm),
        .rf_data       (rf_data),
        .rf_tag        (rf_tag),
        .store_release (store_release),
        .store_tag     (store_tag),
        .flush         (flush),
        .redirect_pc   (redirect_pc)
    );

endmodule

//--- testbench/rob_properties.sv
`timescale 1ns/1ps

module rob_properties (
    input logic                   clk,
    input logic                   rst,
    input logic                   flush,
    input logic                   full,
    input logic                   rf_we,
    input logic                   store_release,
    input rob_pkg::commit_state_t state
);
    import rob_pkg::*;

    int violations = 0;

    // single-cycle redirect pulse
    a_flush_pulse: assert property (@(posedge clk) disable iff (rst) flush |=> !flush)
        else begin
            violations = violations + 1;
            $error("flush stayed high for two cycles");
        end

    a_one_port: assert property (@(posedge clk) disable iff (rst) !(rf_we && store_release))
        else begin
            violations = violations + 1;
            $error("register write and store release in the same cycle");
        end

    a_store_flush: assert property (@(posedge clk) disable iff (rst) !(store_release && flush))
        else begin
            violations = violations + 1;
            $error("store release together with flush");
        end

    // front end is held off while the buffer empties
    a_full_flush: assert property (@(posedge clk) disable iff (rst)
        flush |-> (full && state == st_flush))
        else begin
            violations = violations + 1;
            $error("full low or FSM not flushing while flush is high");
        end

endmodule

bind rob_top rob_properties rob_properties_i (
    .clk           (clk),
    .rst           (rst),
    .flush         (flush),
    .full          (full),
    .rf_we         (rf_we),
    .store_release (store_release),
    .state         (rob_ctrl_i.state)
);

//--- testbench/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;
    import rob_pkg::*;

    typedef struct packed {
        tag_t   tag;
        regnm_t regnm;
        data_t  data;
        addr_t  target;
        logic   is_store;
        logic   is_branch;
        logic   taken;
        logic   mispredict;
    } entry_t;

    logic   clk = 1'b0;
    logic   rst;
    logic   alloc_en, alloc_is_store, alloc_pred_taken;
    regnm_t alloc_regnm;
    tag_t   alloc_tag;
    logic   full;
    logic   ex_en, ex_taken, lsb_en;
    tag_t   ex_tag, lsb_tag;
    data_t  ex_data, lsb_data;
    addr_t  ex_target;
    logic   rf_we, store_release, flush;
    regnm_t rf_regnm;
    data_t  rf_data;
    tag_t   rf_tag, store_tag;
    addr_t  redirect_pc;

    // program order model and the entries still waiting for a result
    entry_t exp_q[$];
    entry_t pend_q[$];
    int     next_tag = 0;

    rob_top rob_top_i (.*);

    always #20 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string msg);
        stop_with_failure($sformatf("Mismatch at %0t ns: %s", $time, msg));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic allocate(input regnm_t regnm, input logic is_store, input logic is_branch,
                            input logic pred, input logic taken);
        entry_t e;
        int     waited;
        waited = 0;
        while (full) begin
            next_cycle();
            waited++;
            if (waited > 200) begin
                stop_with_failure("timed out waiting for a free buffer entry");
            end
        end
        e.tag = tag_t'(next_tag);
        e.regnm = regnm;
        e.data = $urandom;
        e.target = $urandom;
        e.is_store = is_store;
        e.is_branch = is_branch;
        // plain entries complete with their prediction unchanged
        e.taken = is_branch ? taken : pred;
        e.mispredict = is_branch && (pred != taken);
        alloc_en = 1'b1;
        alloc_regnm = regnm;
        alloc_is_store = is_store;
        alloc_pred_taken = pred;
        #1;
        assert (alloc_tag == e.tag)
            else report_mismatch($sformatf("alloc tag %0d, expected %0d", alloc_tag, e.tag));
        next_cycle();
        alloc_en = 1'b0;
        exp_q.push_back(e);
        pend_q.push_back(e);
        next_tag = (next_tag + 1) % 16;
    endtask

    task automatic complete_all();
        entry_t e;
        int     idx;
        while (pend_q.size() > 0) begin
            idx = $urandom % pend_q.size();
            e = pend_q[idx];
            pend_q.delete(idx);
            if (e.is_branch || (!e.is_store && ($urandom % 2) == 1)) begin
                ex_en = 1'b1;
                ex_tag = e.tag;
                ex_data = e.data;
                ex_taken = e.taken;
                ex_target = e.target;
            end else begin
                lsb_en = 1'b1;
                lsb_tag = e.tag;
                lsb_data = e.data;
            end
            next_cycle();
            ex_en = 1'b0;
            lsb_en = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() > 0) begin
            next_cycle();
            waited++;
            if (waited > 200) begin
                stop_with_failure("timed out waiting for the buffer to commit its entries");
            end
        end
        next_cycle();
    endtask

    always @(negedge clk) begin : commit_monitor
        entry_t e;
        if (!rst && (rf_we || store_release || flush)) begin
            assert (exp_q.size() > 0) else report_mismatch("commit with no entry outstanding");
            e = exp_q.pop_front();
            assert (store_release == e.is_store && rf_we == !e.is_store)
                else report_mismatch($sformatf("tag %0d committed on the wrong port", e.tag));
            if (e.is_store) begin
                assert (store_tag == e.tag)
                    else report_mismatch($sformatf("store tag %0d, expected %0d",
                        store_tag, e.tag));
            end else begin
                assert (rf_tag == e.tag && rf_regnm == e.regnm && rf_data == e.data)
                    else report_mismatch($sformatf(
                        "rf write tag %0d reg %0d data %h, expected %0d %0d %h",
                        rf_tag, rf_regnm, rf_data, e.tag, e.regnm, e.data));
            end
            assert (flush == e.mispredict)
                else report_mismatch($sformatf("flush %0b at tag %0d, expected %0b",
                    flush, e.tag, e.mispredict));
            if (e.mispredict) begin
                assert (redirect_pc == e.target && full)
                    else report_mismatch($sformatf("redirect %h full %0b, expected %h with full",
                        redirect_pc, full, e.target));
                // younger entries squashed and tags restart at 0
                exp_q.delete();
                next_tag = 0;
            end
        end
    end

    always @(negedge clk) begin
        if (rob_top_i.rob_properties_i.violations != 0) begin
            stop_with_failure("a protocol property on the DUT outputs failed");
        end
    end

    initial begin
        void'($urandom(32'h3b71_82c6));
        rst = 1'b1;
        alloc_en = 1'b0;
        alloc_regnm = '0;
        alloc_is_store = 1'b0;
        alloc_pred_taken = 1'b0;
        ex_en = 1'b0;
        ex_tag = '0;
        ex_data = '0;
        ex_taken = 1'b0;
        ex_target = '0;
        lsb_en = 1'b0;
        lsb_tag = '0;
        lsb_data = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        // shuffled results with in-order commit
        for (int i = 0; i < 8; i++) begin
            allocate(regnm_t'(i + 1), 1'b0, 1'b0, 1'b0, 1'b0);
        end
        complete_all();
        wait_drain();

        for (int i = 0; i < 6; i++) begin
            allocate(regnm_t'(i + 10), i[0], 1'b0, 1'b0, 1'b0);
        end
        complete_all();
        wait_drain();

        // fill all sixteen slots then push against full
        for (int i = 0; i < 16; i++) begin
            allocate(regnm_t'(i), (i % 3) == 0, 1'b0, 1'b0, 1'b0);
        end
        assert (full) else report_mismatch("full low with sixteen entries allocated");
        alloc_en = 1'b1;
        repeat (3) begin
            next_cycle();
            assert (full) else report_mismatch("full dropped without any commit");
        end
        alloc_en = 1'b0;
        complete_all();
        wait_drain();

        // taken prediction with a not taken outcome
        allocate(5'd7, 1'b0, 1'b1, 1'b1, 1'b0);
        for (int i = 0; i < 3; i++) begin
            allocate(regnm_t'(i + 20), 1'b0, 1'b0, 1'b0, 1'b0);
        end
        complete_all();
        wait_drain();

        allocate(5'd9, 1'b0, 1'b1, 1'b1, 1'b1);
        allocate(5'd10, 1'b0, 1'b0, 1'b0, 1'b0);
        complete_all();
        wait_drain();

        if (rob_top_i.rob_properties_i.violations != 0) begin
            stop_with_failure("a protocol property on the DUT outputs failed at end of run");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

//--- files.f
+incdir+src
src/rob_pkg.sv
src/rob_if.sv
src/rob_ctrl.sv
src/rob_entry_file.sv
src/rob_retire.sv
src/rob_top.sv
testbench/rob_properties.sv
testbench/rob_tb.sv
